//--- design/io_pkg.sv
// ------------------------------------------------------------------------
// I/O readiness gate package
// Address map, operand layout and opcode usage bits shared by the gate
// ------------------------------------------------------------------------

`default_nettype none

package io_pkg;

    // ------------------------------------------------------------------------
    // Address map

    localparam int ADDR_WIDTH       = 10;
    localparam int PORT_COUNT       = 4;
    localparam int PORT_INDEX_WIDTH = 2;

    // Both windows are aligned to PORT_COUNT
    localparam logic [ADDR_WIDTH-1:0] READ_PORT_BASE  = 10'h3F0;
    localparam logic [ADDR_WIDTH-1:0] WRITE_PORT_BASE = 10'h3F8;

    // ------------------------------------------------------------------------
    // Instruction layout, from the top: opcode, D, A, B

    localparam int OPCODE_WIDTH = 4;
    localparam int INSTR_WIDTH  = OPCODE_WIDTH + 3 * ADDR_WIDTH;

    localparam int B_LSB      = 0;
    localparam int A_LSB      = B_LSB + ADDR_WIDTH;
    localparam int D_LSB      = A_LSB + ADDR_WIDTH;
    localparam int OPCODE_LSB = D_LSB + ADDR_WIDTH;

    // Operand slots
    localparam int OPERAND_COUNT = 3;
    localparam int OPERAND_A     = 0;
    localparam int OPERAND_B     = 1;
    localparam int OPERAND_D     = 2;

    // Port window per operand slot, slot 0 in the low word
    // Sources look at read ports, the destination at write ports
    localparam logic [OPERAND_COUNT-1:0][ADDR_WIDTH-1:0] OPERAND_BASE =
        {WRITE_PORT_BASE, READ_PORT_BASE, READ_PORT_BASE};

    // Opcode bits marking each operand as used
    // Bit 0 belongs to the datapath
    localparam int USE_A_BIT = 1;
    localparam int USE_B_BIT = 2;
    localparam int USE_D_BIT = 3;

endpackage

`default_nettype wire

//--- design/operand_decode.sv
// ------------------------------------------------------------------------
// Operand decode
// Splits an instruction into operand addresses and a used mask, and
// delays the control fields to line up with the port checks
// ------------------------------------------------------------------------

`default_nettype none

module operand_decode (
    input  logic                                                   clock,
    input  logic                                                   arst_n,
    input  logic                                                   instr_valid,
    input  logic [io_pkg::INSTR_WIDTH-1:0]                         instr,
    output logic [io_pkg::OPERAND_COUNT-1:0][io_pkg::ADDR_WIDTH-1:0] operand_addr,
    output logic                                                   enable,
    output logic                                                   valid_d,
    output logic [io_pkg::OPERAND_COUNT-1:0]                       used_d,
    output logic [io_pkg::OPERAND_COUNT-1:0][io_pkg::PORT_INDEX_WIDTH-1:0] port_index_d
);

    logic [io_pkg::OPCODE_WIDTH-1:0]  opcode;
    logic [io_pkg::OPERAND_COUNT-1:0] used;

    // ------------------------------------------------------------------------
    // Field slicing, straight to the checkers

    assign opcode = instr[io_pkg::OPCODE_LSB +: io_pkg::OPCODE_WIDTH];

    assign operand_addr[io_pkg::OPERAND_A] = instr[io_pkg::A_LSB +: io_pkg::ADDR_WIDTH];
    assign operand_addr[io_pkg::OPERAND_B] = instr[io_pkg::B_LSB +: io_pkg::ADDR_WIDTH];
    assign operand_addr[io_pkg::OPERAND_D] = instr[io_pkg::D_LSB +: io_pkg::ADDR_WIDTH];

    // Checkers look at the port only while an instruction is present
    assign enable = instr_valid;

    // Usage bits from the opcode
    assign used[io_pkg::OPERAND_A] = opcode[io_pkg::USE_A_BIT];
    assign used[io_pkg::OPERAND_B] = opcode[io_pkg::USE_B_BIT];
    assign used[io_pkg::OPERAND_D] = opcode[io_pkg::USE_D_BIT];

    // ------------------------------------------------------------------------
    // One stage of delay, matching the checker's first register

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_d      <= 1'b0;
            used_d       <= '0;
            port_index_d <= '0;
        end else begin
            valid_d <= instr_valid;
            // Idle cycles carry an empty mask
            used_d  <= instr_valid ? used : '0;
            // Windows are aligned, so the low address bits pick the port
            for (int i = 0; i < io_pkg::OPERAND_COUNT; i++) begin
                port_index_d[i] <= operand_addr[i][io_pkg::PORT_INDEX_WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/io_check.sv
// ------------------------------------------------------------------------
// Per-operand I/O check
// Detects a port address in the window at PORT_BASE and returns the
// ready bit of that port, forced ready for memory, not-ready when idle
// ------------------------------------------------------------------------

`default_nettype none

module io_check #(
    parameter logic [io_pkg::ADDR_WIDTH-1:0] PORT_BASE = io_pkg::READ_PORT_BASE
) (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            enable,
    input  logic [io_pkg::ADDR_WIDTH-1:0]   addr,
    input  logic [io_pkg::PORT_COUNT-1:0]   port_ready,
    output logic                            operand_ready,
    output logic                            is_io
);

    // Window tag, the address bits above the port index
    localparam int TAG_WIDTH = io_pkg::ADDR_WIDTH - io_pkg::PORT_INDEX_WIDTH;
    localparam logic [TAG_WIDTH-1:0] PORT_TAG =
        PORT_BASE[io_pkg::ADDR_WIDTH-1:io_pkg::PORT_INDEX_WIDTH];

    logic                                 hit;
    logic                                 ready_sel;
    logic [io_pkg::PORT_INDEX_WIDTH-1:0]  port_index;

    logic                                 ready_q;
    logic                                 enable_q;

    // ------------------------------------------------------------------------
    // Stage 1: window hit and port select

    assign port_index = addr[io_pkg::PORT_INDEX_WIDTH-1:0];

    // Only a present instruction can hit the window
    assign hit = enable && (addr[io_pkg::ADDR_WIDTH-1:io_pkg::PORT_INDEX_WIDTH] == PORT_TAG);

    // Ready bit of the addressed port, meaningful only on a hit
    assign ready_sel = port_ready[port_index];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            is_io    <= 1'b0;
            ready_q  <= 1'b0;
            enable_q <= 1'b0;
        end else begin
            is_io    <= hit;
            ready_q  <= ready_sel;
            enable_q <= enable;
        end
    end

    // ------------------------------------------------------------------------
    // Stage 2: mask
    // Idle gives not-ready, memory is always ready, a port gives its bit

    always_comb begin
        if (!enable_q) begin
            operand_ready = 1'b0;
        end else if (!is_io) begin
            operand_ready = 1'b1;
        end else begin
            operand_ready = ready_q;
        end
    end

endmodule

`default_nettype wire

//--- design/io_predicate.sv
// ------------------------------------------------------------------------
// Issue predicate
// Combines the operand checks into issue or stall, and raises the read
// and write strobes of the ports an issued instruction uses
// ------------------------------------------------------------------------

`default_nettype none

module io_predicate (
    input  logic                                   clock,
    input  logic                                   arst_n,
    input  logic                                   valid_d,
    input  logic [io_pkg::OPERAND_COUNT-1:0]       used_d,
    input  logic [io_pkg::OPERAND_COUNT-1:0][io_pkg::PORT_INDEX_WIDTH-1:0] port_index_d,
    input  logic [io_pkg::OPERAND_COUNT-1:0]       operand_ready,
    input  logic [io_pkg::OPERAND_COUNT-1:0]       is_io,
    output logic                                   issue,
    output logic                                   stall,
    output logic [io_pkg::PORT_COUNT-1:0]          read_strobe,
    output logic [io_pkg::PORT_COUNT-1:0]          write_strobe
);

    logic [io_pkg::OPERAND_COUNT-1:0] effective_ready;
    logic [io_pkg::OPERAND_COUNT-1:0] port_used;
    logic                             all_ready;
    logic                             issue_next;
    logic                             stall_next;
    logic [io_pkg::PORT_COUNT-1:0]    read_next;
    logic [io_pkg::PORT_COUNT-1:0]    write_next;

    // ------------------------------------------------------------------------
    // Issue decision

    // Unused operands never hold the instruction back
    assign effective_ready = ~used_d | operand_ready;
    assign all_ready       = &effective_ready;

    assign issue_next = valid_d && all_ready;
    assign stall_next = valid_d && !all_ready;

    // Operand touches a port and the opcode says it is used
    assign port_used = used_d & is_io;

    // ------------------------------------------------------------------------
    // Strobe decode
    // A and B on the same port collapse into one strobe bit

    always_comb begin
        read_next  = '0;
        write_next = '0;
        if (issue_next) begin
            if (port_used[io_pkg::OPERAND_A]) begin
                read_next[port_index_d[io_pkg::OPERAND_A]] = 1'b1;
            end
            if (port_used[io_pkg::OPERAND_B]) begin
                read_next[port_index_d[io_pkg::OPERAND_B]] = 1'b1;
            end
            if (port_used[io_pkg::OPERAND_D]) begin
                write_next[port_index_d[io_pkg::OPERAND_D]] = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Output register, second pipeline stage

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            issue        <= 1'b0;
            stall        <= 1'b0;
            read_strobe  <= '0;
            write_strobe <= '0;
        end else begin
            issue        <= issue_next;
            stall        <= stall_next;
            read_strobe  <= read_next;
            write_strobe <= write_next;
        end
    end

endmodule

`default_nettype wire

//--- design/io_gate_top.sv
// ------------------------------------------------------------------------
// I/O readiness gate
// Decides two cycles after an instruction whether it issues or stalls
// on the readiness of the I/O ports its operands address
// ------------------------------------------------------------------------

`default_nettype none

module io_gate_top (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            instr_valid,
    input  logic [io_pkg::INSTR_WIDTH-1:0]  instr,
    input  logic [io_pkg::PORT_COUNT-1:0]   read_ready,
    input  logic [io_pkg::PORT_COUNT-1:0]   write_ready,
    output logic                            issue,
    output logic                            stall,
    output logic [io_pkg::PORT_COUNT-1:0]   read_strobe,
    output logic [io_pkg::PORT_COUNT-1:0]   write_strobe
);

    // Decode to checkers, same cycle
    logic [io_pkg::OPERAND_COUNT-1:0][io_pkg::ADDR_WIDTH-1:0] operand_addr;
    logic                                                     enable;

    // Decode to predicate, one cycle later
    logic                                                     valid_d;
    logic [io_pkg::OPERAND_COUNT-1:0]                         used_d;
    logic [io_pkg::OPERAND_COUNT-1:0][io_pkg::PORT_INDEX_WIDTH-1:0] port_index_d;

    // Checkers to predicate
    logic [io_pkg::OPERAND_COUNT-1:0]                         operand_ready;
    logic [io_pkg::OPERAND_COUNT-1:0]                         is_io;

    operand_decode u_decode (
        .clock        (clock),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .operand_addr (operand_addr),
        .enable       (enable),
        .valid_d      (valid_d),
        .used_d       (used_d),
        .port_index_d (port_index_d)
    );

    // ------------------------------------------------------------------------
    // One checker per operand
    // Sources see the read ports, the destination sees the write ports

    for (genvar i = 0; i < io_pkg::OPERAND_COUNT; i++) begin : g_check
        io_check #(
            .PORT_BASE (io_pkg::OPERAND_BASE[i])
        ) u_check (
            .clock         (clock),
            .arst_n        (arst_n),
            .enable        (enable),
            .addr          (operand_addr[i]),
            .port_ready    ((i == io_pkg::OPERAND_D) ? write_ready : read_ready),
            .operand_ready (operand_ready[i]),
            .is_io         (is_io[i])
        );
    end

    io_predicate u_predicate (
        .clock         (clock),
        .arst_n        (arst_n),
        .valid_d       (valid_d),
        .used_d        (used_d),
        .port_index_d  (port_index_d),
        .operand_ready (operand_ready),
        .is_io         (is_io),
        .issue         (issue),
        .stall         (stall),
        .read_strobe   (read_strobe),
        .write_strobe  (write_strobe)
    );

endmodule

`default_nettype wire

//--- bench/io_gate_tb.sv
// ------------------------------------------------------------------------
// I/O readiness gate testbench
// Random instructions and port readiness against a reference model
// ------------------------------------------------------------------------

`default_nettype none

module io_gate_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD = 40;
    localparam int STIM_CYCLES  = 400;
    localparam int WATCHDOG_NS  = (STIM_CYCLES + 20) * CLOCK_PERIOD;

    logic                           clock;
    logic                           arst_n;
    logic                           instr_valid;
    logic [io_pkg::INSTR_WIDTH-1:0] instr;
    logic [io_pkg::PORT_COUNT-1:0]  read_ready;
    logic [io_pkg::PORT_COUNT-1:0]  write_ready;
    logic                           issue;
    logic                           stall;
    logic [io_pkg::PORT_COUNT-1:0]  read_strobe;
    logic [io_pkg::PORT_COUNT-1:0]  write_strobe;

    // Expected {issue, stall, read_strobe, write_strobe}, oldest first
    logic [9:0]  exp_q[$];
    logic [31:0] lcg_state;
    int          error_count;
    int          check_count;
    int          issue_count;
    int          stall_count;

    io_gate_top dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .read_ready   (read_ready),
        .write_ready  (write_ready),
        .issue        (issue),
        .stall        (stall),
        .read_strobe  (read_strobe),
        .write_strobe (write_strobe)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // ------------------------------------------------------------------------
    // Random numbers and stimulus

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // About half land in a port window, read or write at random
    function automatic logic [9:0] pick_addr();
        logic [31:0] r;
        logic [9:0]  base;
        r = next_rand();
        if (r[31]) begin
            base = r[30] ? io_pkg::WRITE_PORT_BASE : io_pkg::READ_PORT_BASE;
            return base + {8'h00, r[29:28]};
        end
        return r[25:16];
    endfunction

    // Reference model from the issue rules
    function automatic logic [9:0] expected_outputs(input logic valid, input logic [33:0] word,
                                                   input logic [3:0] rd_rdy,
                                                   input logic [3:0] wr_rdy);
        logic [3:0] opcode;
        logic [9:0] off_a;
        logic [9:0] off_b;
        logic [9:0] off_d;
        logic       all_ready;
        logic [3:0] rs;
        logic [3:0] ws;
        opcode = word[33:30];
        // Offsets into the window each operand may use
        off_d = word[29:20] - io_pkg::WRITE_PORT_BASE;
        off_a = word[19:10] - io_pkg::READ_PORT_BASE;
        off_b = word[9:0] - io_pkg::READ_PORT_BASE;
        all_ready = 1'b1;
        rs = '0;
        ws = '0;
        if (opcode[io_pkg::USE_A_BIT] && off_a < 10'(io_pkg::PORT_COUNT)) begin
            all_ready = all_ready & rd_rdy[off_a[1:0]];
            rs[off_a[1:0]] = 1'b1;
        end
        if (opcode[io_pkg::USE_B_BIT] && off_b < 10'(io_pkg::PORT_COUNT)) begin
            all_ready = all_ready & rd_rdy[off_b[1:0]];
            rs[off_b[1:0]] = 1'b1;
        end
        if (opcode[io_pkg::USE_D_BIT] && off_d < 10'(io_pkg::PORT_COUNT)) begin
            all_ready = all_ready & wr_rdy[off_d[1:0]];
            ws[off_d[1:0]] = 1'b1;
        end
        if (!valid) begin
            return '0;
        end
        if (!all_ready) begin
            return {2'b01, 8'h00};
        end
        return {2'b10, rs, ws};
    endfunction

    // Valid with probability 3/4, random opcode and readiness
    task automatic drive_random();
        logic [31:0] r;
        logic [9:0]  expected;
        r = next_rand();
        instr_valid = (r[31:30] != 2'b00);
        read_ready  = r[23:20];
        write_ready = r[19:16];
        instr = {r[27:24], pick_addr(), pick_addr(), pick_addr()};
        expected = expected_outputs(instr_valid, instr, read_ready, write_ready);
        if (expected[9]) issue_count++;
        if (expected[8]) stall_count++;
        exp_q.push_back(expected);
    endtask

    task automatic drive_idle();
        instr_valid = 1'b0;
        exp_q.push_back('0);
    endtask

    // ------------------------------------------------------------------------
    // Output checks, two cycles behind the drive

    task automatic compare_field(input string name, input logic [3:0] expected,
                                 input logic [3:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clock) begin : check_outputs
        logic [9:0] expected;
        if (arst_n && exp_q.size() > 2) begin
            expected = exp_q.pop_front();
            compare_field("issue", 4'(expected[9]), 4'(issue));
            compare_field("stall", 4'(expected[8]), 4'(stall));
            compare_field("read_strobe", expected[7:4], read_strobe);
            compare_field("write_strobe", expected[3:0], write_strobe);
            check_count++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the stimulus finished");
        $display("test failed");
        $finish;
    end

    initial begin
        lcg_state   = 32'hf960_66e6;
        error_count = 0;
        check_count = 0;
        issue_count = 0;
        stall_count = 0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        read_ready  = '0;
        write_ready = '0;
        // Outputs stay low for the first two cycles after reset
        exp_q.push_back('0);
        exp_q.push_back('0);
        repeat (2) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        for (int cycle = 0; cycle < STIM_CYCLES; cycle++) begin
            drive_random();
            @(negedge clock);
        end
        // Flush the last two instructions
        drive_idle();
        @(negedge clock);
        drive_idle();
        @(negedge clock);
        assert (issue_count > 0 && stall_count > 0) else begin
            error_count++;
            $display("Stimulus never produced both an issue and a stall");
        end
        $display("checks %0d, issues %0d, stalls %0d, errors %0d",
                 check_count, issue_count, stall_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/io_pkg.sv
design/operand_decode.sv
design/io_check.sv
design/io_predicate.sv
design/io_gate_top.sv
bench/io_gate_tb.sv

//--- Makefile
# Verilator build for the I/O readiness gate

VERILATOR    ?= verilator
TOP          := io_gate_tb
FILE_LIST    := build.f
BUILD_DIR    := obj_dir
LINT_FLAGS   := --lint-only -Wall --timing
SIM_FLAGS    := --binary --timing --assert -j 0
PASS_MESSAGE := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# The run passes only if the pass message appears as a line of its own
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MESSAGE)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
